/* Makefile */
SRCS := $(wildcard logic/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vsched_tb: project.f $(SRCS)
	verilator --binary --timing --assert --top-module sched_tb -f project.f

run: obj_dir/Vsched_tb
	./obj_dir/Vsched_tb | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

/* logic/dispatch_router.sv */
// =========================================================================
// Steers each dispatched micro-op to the station picked by its FU code
// Stomped dispatches vanish and dispatches to a full station are dropped
// =========================================================================
`timescale 1ns/1ps

module dispatch_router import sched_pkg::*; #(
	parameter int NUM_FU = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  micro_op_t         disp_i,
	input  rob_mask_t         stomp_i,
	input  logic [NUM_FU-1:0] full_i,
	output logic [NUM_FU-1:0] alloc_o,
	output micro_op_t         op_o,
	output logic              drop_o
);

	logic [NUM_FU-1:0] target;
	logic              accept;
	logic              refused;

	// One-hot decode of the FU code, limited to the stations that exist
	always_comb begin
		for (int k = 0; k < NUM_FU; k++) begin
			target[k] = (disp_i.fu == fu_e'(k));
		end
	end

	// A dispatch whose ROB slot is being stomped is never written
	assign accept = disp_i.valid & ~stomp_i[disp_i.rob];

	assign alloc_o = target & ~full_i & {NUM_FU{accept}};
	assign refused = accept & |(target & full_i);

	// All stations see the same copy of the micro-op
	assign op_o = disp_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			drop_o <= 1'b0;
		end else begin
			drop_o <= refused;
		end
	end

endmodule

/* logic/issue_select.sv */
// =========================================================================
// Round-robin selector that drains the stations onto one issue port
// The port is registered, so an op appears the cycle after its grant
// =========================================================================
`timescale 1ns/1ps

module issue_select import sched_pkg::*; #(
	parameter int NUM_FU = 4
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic       [NUM_FU-1:0] req_i,
	input  issued_op_t [NUM_FU-1:0] cand_i,
	input  logic                    stall_i,
	input  rob_mask_t               stomp_i,
	output logic       [NUM_FU-1:0] grant_o,
	output logic                    issue_o,
	output issued_op_t              issue_op_o
);

	localparam int PTR_W = (NUM_FU > 1) ? $clog2(NUM_FU) : 1;

	logic [PTR_W-1:0] ptr_q;
	logic [PTR_W-1:0] next_ptr;
	logic [PTR_W-1:0] win_idx;
	logic             win_found;
	issued_op_t       win_op;

	// Search starts at the pointer and wraps around once
	always_comb begin
		int idx;
		win_found = 1'b0;
		win_idx = '0;
		for (int off = 0; off < NUM_FU; off++) begin
			idx = (int'(ptr_q) + off) % NUM_FU;
			if (!win_found && req_i[idx]) begin
				win_found = 1'b1;
				win_idx = PTR_W'(idx);
			end
		end
	end

	assign grant_o = (win_found && !stall_i) ? (NUM_FU'(1) << win_idx) : '0;
	assign win_op = cand_i[win_idx];

	// Pointer moves just past the station that won
	assign next_ptr = (int'(win_idx) == NUM_FU - 1) ? '0 : win_idx + PTR_W'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			ptr_q <= '0;
			issue_o <= 1'b0;
		end else begin
			// The station frees a stomped entry anyway, so only the strobe is masked
			issue_o <= |grant_o & ~stomp_i[win_op.rob];
			if (|grant_o) begin
				ptr_q <= next_ptr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (|grant_o) begin
			issue_op_o <= win_op;
		end
	end

endmodule

/* logic/operand_capture.sv */
// =========================================================================
// Wakeup compare for one source operand against the result broadcast
// Purely combinational, used for stored entries and for incoming ops
// =========================================================================
`timescale 1ns/1ps

module operand_capture import sched_pkg::*; (
	input  operand_t    opnd_i,
	input  result_bus_t wb_i,
	output operand_t    opnd_o
);

	logic hit;

	// Only a waiting operand listens to the broadcast
	assign hit = ~opnd_i.valid & wb_i.valid & (wb_i.dst == opnd_i.preg);

	always_comb begin
		opnd_o = opnd_i;
		if (hit) begin
			// Take the broadcast value and mark the operand as ready
			opnd_o.valid = 1'b1;
			opnd_o.value = wb_i.value;
		end
	end

endmodule

/* logic/reservation_station.sv */
// =========================================================================
// One reservation station of NUM_ENT entries for a single functional unit
// Entries wake up on the broadcast and the lowest ready one is offered
// =========================================================================
`timescale 1ns/1ps

module reservation_station import sched_pkg::*; #(
	parameter int NUM_ENT = 3
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        alloc_i,
	input  micro_op_t   op_i,
	input  result_bus_t wb_i,
	input  rob_mask_t   stomp_i,
	input  logic        grant_i,
	output logic        full_o,
	output logic        req_o,
	output issued_op_t  cand_o
);

	// Entry storage, occupancy is tracked separately in busy_q
	micro_op_t          ent_q [NUM_ENT];
	logic [NUM_ENT-1:0] busy_q;

	operand_t           cap_a [NUM_ENT];
	operand_t           cap_b [NUM_ENT];
	operand_t           in_a;
	operand_t           in_b;
	micro_op_t          op_cap;

	logic [NUM_ENT-1:0] rdy;
	logic [NUM_ENT-1:0] kill;
	logic [NUM_ENT-1:0] sel_oh;
	logic [NUM_ENT-1:0] free_oh;
	logic [NUM_ENT-1:0] release_oh;
	logic [NUM_ENT-1:0] write_oh;

	// =====================================================================
	// Operand wakeup
	// =====================================================================

	// A broadcast in the dispatch cycle is caught before the entry is written
	operand_capture i_cap_in_a (
		.opnd_i(op_i.src_a),
		.wb_i(wb_i),
		.opnd_o(in_a)
	);

	operand_capture i_cap_in_b (
		.opnd_i(op_i.src_b),
		.wb_i(wb_i),
		.opnd_o(in_b)
	);

	always_comb begin
		op_cap = op_i;
		op_cap.src_a = in_a;
		op_cap.src_b = in_b;
	end

	for (genvar i = 0; i < NUM_ENT; i++) begin : g_ent
		operand_capture i_cap_a (
			.opnd_i(ent_q[i].src_a),
			.wb_i(wb_i),
			.opnd_o(cap_a[i])
		);

		operand_capture i_cap_b (
			.opnd_i(ent_q[i].src_b),
			.wb_i(wb_i),
			.opnd_o(cap_b[i])
		);

		// Readiness uses the stored valid bits, so req follows the write by a cycle
		assign rdy[i] = busy_q[i] & ent_q[i].src_a.valid & ent_q[i].src_b.valid;
		assign kill[i] = busy_q[i] & stomp_i[ent_q[i].rob];
	end

	// =====================================================================
	// Selection and allocation
	// =====================================================================

	// Lowest set bit of the ready vector and lowest clear bit of busy
	assign sel_oh = rdy & (~rdy + NUM_ENT'(1));
	assign free_oh = ~busy_q & (busy_q + NUM_ENT'(1));

	assign req_o = |rdy;
	assign full_o = &busy_q;

	assign release_oh = kill | (sel_oh & {NUM_ENT{grant_i}});
	assign write_oh = free_oh & {NUM_ENT{alloc_i}};

	always_comb begin
		cand_o = '0;
		for (int i = 0; i < NUM_ENT; i++) begin
			if (sel_oh[i]) begin
				cand_o.rob = ent_q[i].rob;
				cand_o.op = ent_q[i].op;
				cand_o.dst = ent_q[i].dst;
				cand_o.val_a = ent_q[i].src_a.value;
				cand_o.val_b = ent_q[i].src_b.value;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy_q <= '0;
		end else begin
			busy_q <= (busy_q & ~release_oh) | write_oh;
		end
	end

	// Waiting operands are refreshed from the broadcast every cycle
	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_ENT; i++) begin
			if (write_oh[i]) begin
				ent_q[i] <= op_cap;
			end else begin
				ent_q[i].src_a <= cap_a[i];
				ent_q[i].src_b <= cap_b[i];
			end
		end
	end

endmodule

/* logic/sched_pkg.sv */
// =========================================================================
// Widths, codes and bus structures shared across the issue stage
// Imported by every RTL module and by the testbench
// =========================================================================
package sched_pkg;

	// Physical register number and operand value widths
	localparam int PREG_W = 7;
	localparam int VALUE_W = 32;

	// One stomp mask bit per reorder-buffer slot
	localparam int ROB_DEPTH = 16;

	typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;
	typedef logic [ROB_DEPTH-1:0] rob_mask_t;

	// Functional-unit code, which also selects the reservation station
	typedef enum logic [1:0] {
		FU_ALU = 2'd0,
		FU_MUL = 2'd1,
		FU_MEM = 2'd2,
		FU_BR  = 2'd3
	} fu_e;

	typedef enum logic [3:0] {
		OP_NOP   = 4'h0,
		OP_ADD   = 4'h1,
		OP_SUB   = 4'h2,
		OP_AND   = 4'h3,
		OP_OR    = 4'h4,
		OP_MUL   = 4'h5,
		OP_LOAD  = 4'h6,
		OP_STORE = 4'h7,
		OP_BEQ   = 4'h8,
		OP_BNE   = 4'h9
	} opcode_e;

	// =====================================================================
	// Bus structures
	// =====================================================================

	typedef struct packed {
		logic               valid;
		logic [PREG_W-1:0]  preg;
		logic [VALUE_W-1:0] value;
	} operand_t;

	typedef struct packed {
		logic              valid;
		fu_e               fu;
		opcode_e           op;
		rob_idx_t          rob;
		logic [PREG_W-1:0] dst;
		operand_t          src_a;
		operand_t          src_b;
	} micro_op_t;

	// Result broadcast, at most one per cycle
	typedef struct packed {
		logic               valid;
		logic [PREG_W-1:0]  dst;
		logic [VALUE_W-1:0] value;
	} result_bus_t;

	typedef struct packed {
		rob_idx_t           rob;
		opcode_e            op;
		logic [PREG_W-1:0]  dst;
		logic [VALUE_W-1:0] val_a;
		logic [VALUE_W-1:0] val_b;
	} issued_op_t;

endpackage

/* logic/sched_top.sv */
// =========================================================================
// Issue stage top level with the router, NUM_FU stations and the selector
// NUM_FU must stay within the four codes of fu_e
// =========================================================================
`timescale 1ns/1ps

module sched_top import sched_pkg::*; #(
	parameter int NUM_FU  = 4,
	parameter int NUM_ENT = 3
) (
	input  logic              clk,
	input  logic              rst,
	input  micro_op_t         disp_i,
	input  result_bus_t       wb_i,
	input  rob_mask_t         stomp_i,
	input  logic              stall_i,
	output logic              issue_o,
	output issued_op_t        issue_op_o,
	output logic [NUM_FU-1:0] full_o,
	output logic              disp_drop_o
);

	logic       [NUM_FU-1:0] alloc;
	logic       [NUM_FU-1:0] station_full;
	logic       [NUM_FU-1:0] req;
	logic       [NUM_FU-1:0] grant;
	issued_op_t [NUM_FU-1:0] cand;
	micro_op_t               router_op;

	dispatch_router #(
		.NUM_FU(NUM_FU)
	) i_dispatch_router (
		.clk(clk),
		.rst(rst),
		.disp_i(disp_i),
		.stomp_i(stomp_i),
		.full_i(station_full),
		.alloc_o(alloc),
		.op_o(router_op),
		.drop_o(disp_drop_o)
	);

	// Station k serves the functional-unit code k
	for (genvar k = 0; k < NUM_FU; k++) begin : g_rs
		reservation_station #(
			.NUM_ENT(NUM_ENT)
		) i_reservation_station (
			.clk(clk),
			.rst(rst),
			.alloc_i(alloc[k]),
			.op_i(router_op),
			.wb_i(wb_i),
			.stomp_i(stomp_i),
			.grant_i(grant[k]),
			.full_o(station_full[k]),
			.req_o(req[k]),
			.cand_o(cand[k])
		);
	end

	issue_select #(
		.NUM_FU(NUM_FU)
	) i_issue_select (
		.clk(clk),
		.rst(rst),
		.req_i(req),
		.cand_i(cand),
		.stall_i(stall_i),
		.stomp_i(stomp_i),
		.grant_o(grant),
		.issue_o(issue_o),
		.issue_op_o(issue_op_o)
	);

	assign full_o = station_full;

endmodule

/* project.f */
logic/sched_pkg.sv
logic/dispatch_router.sv
logic/operand_capture.sv
logic/reservation_station.sv
logic/issue_select.sv
logic/sched_top.sv
tests/tb_clock.sv
tests/sched_assertions.sv
tests/sched_tb.sv

/* tests/sched_assertions.sv */
// ==========================================================================
// Concurrent checks on the issue port, grants and allocation of sched_top
// Attached to every sched_top instance by the bind at the end of this file
// ==========================================================================
`timescale 1ns/1ps

module sched_assertions import sched_pkg::*; #(
	parameter int NUM_FU = 4
) (
	input logic              clk,
	input logic              rst,
	input logic              issue_i,
	input logic [NUM_FU-1:0] grant_i,
	input logic [NUM_FU-1:0] req_i,
	input logic              stall_i,
	input logic [NUM_FU-1:0] alloc_i,
	input logic [NUM_FU-1:0] full_i,
	input micro_op_t         disp_i,
	input rob_mask_t         stomp_i,
	input logic              drop_i
);

	// The issue strobe stays low through reset and the cycle after it
	issue_low_in_reset: assert property (@(posedge clk) rst |=> !issue_i)
		else $error("issue_o high during or right after reset");

	// Any request without stall yields exactly one grant, to a requesting station
	one_grant_at_most: assert property (@(posedge clk) disable iff (rst)
		$onehot0(grant_i) && ((grant_i & ~req_i) == '0)
			&& ((|grant_i) == ((|req_i) && !stall_i)))
		else $error("grant not given to exactly one requesting station");

	// A dispatch aimed at a full station gets no alloc and is reported as dropped
	no_alloc_when_full: assert property (@(posedge clk) disable iff (rst)
		(disp_i.valid && !stomp_i[disp_i.rob] && full_i[disp_i.fu])
			|-> (alloc_i == '0) ##1 drop_i)
		else $error("dispatch to a full station was not refused");

endmodule

bind sched_top sched_assertions #(
	.NUM_FU(NUM_FU)
) i_sched_assertions (
	.clk(clk),
	.rst(rst),
	.issue_i(issue_o),
	.grant_i(grant),
	.req_i(req),
	.stall_i(stall_i),
	.alloc_i(alloc),
	.full_i(station_full),
	.disp_i(disp_i),
	.stomp_i(stomp_i),
	.drop_i(disp_drop_o)
);

/* tests/sched_tb.sv */
// ==========================================================================
// Trace-driven testbench for the issue stage, run from the project root
// Reads the command trace, drives on falling edges and checks every issue
// ==========================================================================
`timescale 1ns/1ps

module sched_tb import sched_pkg::*; ();

	localparam int NUM_FU = 4;
	localparam int NUM_ENT = 3;

	logic              clk;
	logic              rst;
	micro_op_t         disp;
	result_bus_t       wb;
	rob_mask_t         stomp;
	logic              stall;
	logic              issue;
	issued_op_t        issue_op;
	logic [NUM_FU-1:0] full;
	logic              drop;

	// Parsed trace, ten hex fields per line
	string       name_q[$];
	string       cmd_q[$];
	logic [31:0] fld_q[$];

	issued_op_t  got_q[$];
	int          got_cyc_q[$];
	int          cyc;
	int          last_disp_cyc;
	int          wd_cycles;
	logic        stall_seen;
	int          errors;
	int          checks;
	int          test_err;
	int          tests_run;
	int          tests_failed;
	string       cur_test;

	micro_op_t   p_disp;
	result_bus_t p_wb;
	rob_mask_t   p_stomp;
	logic        p_stall;

	tb_clock i_tb_clock (
		.clk_o(clk)
	);

	sched_top #(
		.NUM_FU(NUM_FU),
		.NUM_ENT(NUM_ENT)
	) i_sched_top (
		.clk(clk),
		.rst(rst),
		.disp_i(disp),
		.wb_i(wb),
		.stomp_i(stomp),
		.stall_i(stall),
		.issue_o(issue),
		.issue_op_o(issue_op),
		.full_o(full),
		.disp_drop_o(drop)
	);

	// The stall seen at an edge decides whether that edge may grant
	always @(posedge clk) begin
		cyc <= cyc + 1;
		stall_seen <= stall;
	end

	always @(negedge clk) begin
		if (!rst && issue) begin
			if (stall_seen) begin
				$display("ERROR in %s: an op issued from a stalled cycle", cur_test);
				errors++;
				test_err++;
			end
			got_q.push_back(issue_op);
			got_cyc_q.push_back(cyc);
		end
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles + 16) @(posedge clk);
		$display("Watchdog expired before the trace finished");
		$display("Test failures found");
		$finish;
	end

	task automatic check_issue(string name, issued_op_t exp, issued_op_t act);
		checks++;
		if (act !== exp) begin
			$display("FAILED %s: expected issue %h, actual %h", name, exp, act);
			errors++;
			test_err++;
		end
	endtask

	task automatic check_full(string name, logic [NUM_FU-1:0] exp_full, logic exp_drop,
			logic [NUM_FU-1:0] act_full, logic act_drop);
		checks++;
		if ({act_full, act_drop} !== {exp_full, exp_drop}) begin
			$display("FAILED %s: expected full %b drop %b, actual full %b drop %b",
				name, exp_full, exp_drop, act_full, act_drop);
			errors++;
			test_err++;
		end
	endtask

	task automatic close_test();
		if (cur_test != "") begin
			$display("test %s: %s", cur_test, (test_err == 0) ? "PASS" : "FAIL");
			tests_run++;
			if (test_err != 0) begin
				tests_failed++;
			end
		end
		test_err = 0;
	endtask

	// Staged inputs hold for one cycle, then n quiet cycles follow
	task automatic apply_cycles(int n);
		@(negedge clk);
		disp = p_disp;
		wb = p_wb;
		stomp = p_stomp;
		stall = p_stall;
		if (p_disp.valid) begin
			last_disp_cyc = cyc;
		end
		p_disp = '0;
		p_wb = '0;
		p_stomp = '0;
		repeat (n) begin
			@(negedge clk);
			disp = '0;
			wb = '0;
			stomp = '0;
		end
	endtask

	task automatic expect_issue(string name, issued_op_t exp, int lat);
		int         waited;
		int         got_cyc;
		issued_op_t act;
		waited = 0;
		while (got_q.size() == 0 && waited < 100) begin
			@(negedge clk);
			#1;
			waited++;
		end
		if (got_q.size() == 0) begin
			$display("ERROR in %s: no issue seen within 100 cycles", name);
			errors++;
			test_err++;
		end else begin
			act = got_q.pop_front();
			got_cyc = got_cyc_q.pop_front();
			check_issue(name, exp, act);
			if (lat != 0 && got_cyc - last_disp_cyc != lat) begin
				$display("FAILED %s: expected latency %0d, actual %0d",
					name, lat, got_cyc - last_disp_cyc);
				errors++;
				test_err++;
			end
		end
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		string       nm;
		string       cm;
		logic [31:0] f [10];
		issued_op_t  exp;
		disp = '0;
		wb = '0;
		stomp = '0;
		stall = 1'b0;
		rst = 1'b1;
		p_disp = '0;
		p_wb = '0;
		p_stomp = '0;
		p_stall = 1'b0;
		cyc = 0;
		errors = 0;
		checks = 0;
		test_err = 0;
		tests_run = 0;
		tests_failed = 0;
		cur_test = "";
		wd_cycles = 0;

		fd = $fopen("tests/sched_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: the trace file could not be opened");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) == 0) begin
					break;
				end
				n = $sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h %h", nm, cm,
					f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
				if (n == 12 && nm.substr(0, 0) != "#") begin
					name_q.push_back(nm);
					cmd_q.push_back(cm);
					for (int k = 0; k < 10; k++) begin
						fld_q.push_back(f[k]);
					end
				end
			end
			$fclose(fd);
		end
		wd_cycles = 20 * name_q.size();

		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		for (int i = 0; i < name_q.size(); i++) begin
			for (int k = 0; k < 10; k++) begin
				f[k] = fld_q[i * 10 + k];
			end
			if (name_q[i] != cur_test) begin
				close_test();
				cur_test = name_q[i];
			end
			case (cmd_q[i])
				"DISP": begin
					p_disp.valid = 1'b1;
					p_disp.fu = fu_e'(f[0][1:0]);
					p_disp.op = opcode_e'(f[1][3:0]);
					p_disp.rob = f[2][3:0];
					p_disp.dst = f[3][PREG_W-1:0];
					p_disp.src_a = '{valid: f[4][0], preg: f[5][PREG_W-1:0], value: f[6]};
					p_disp.src_b = '{valid: f[7][0], preg: f[8][PREG_W-1:0], value: f[9]};
				end
				"WB": p_wb = '{valid: 1'b1, dst: f[0][PREG_W-1:0], value: f[1]};
				"STOMP": p_stomp = f[0][ROB_DEPTH-1:0];
				"STALL": p_stall = f[0][0];
				"IDLE": apply_cycles(int'(f[0]));
				"EXPECT": begin
					if (f[0] == 0) begin
						exp.rob = f[1][3:0];
						exp.op = opcode_e'(f[2][3:0]);
						exp.dst = f[3][PREG_W-1:0];
						exp.val_a = f[4];
						exp.val_b = f[5];
						expect_issue(cur_test, exp, int'(f[6]));
					end else begin
						check_full(cur_test, f[1][NUM_FU-1:0], f[2][0], full, drop);
					end
				end
				default: begin
					$display("ERROR in %s: unknown trace command %s", cur_test, cmd_q[i]);
					errors++;
					test_err++;
				end
			endcase
		end

		// Stomped and dropped ops must never show up
		repeat (10) @(negedge clk);
		if (got_q.size() != 0) begin
			$display("ERROR in %s: %0d ops issued that the trace does not expect",
				cur_test, got_q.size());
			errors++;
			test_err++;
		end
		close_test();
		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* tests/sched_trace.txt */
# name cmd then ten hex fields; DISP: fu op rob dst a_vld a_preg a_val b_vld b_preg b_val
# WB: dst value, STOMP: mask, STALL: level, IDLE: quiet cycles, EXPECT 0: rob op dst a b lat
t1_basic DISP 0 1 1 10 1 01 11111111 1 02 22222222
t1_basic IDLE 3 0 0 0 0 0 0 0 0 0
t1_basic EXPECT 0 1 1 10 11111111 22222222 2 0 0 0
t2_wakeup DISP 1 5 2 20 0 30 0 1 31 5
t2_wakeup IDLE 3 0 0 0 0 0 0 0 0 0
t2_wakeup WB 30 abcd0001 0 0 0 0 0 0 0 0
t2_wakeup IDLE 3 0 0 0 0 0 0 0 0 0
t2_wakeup EXPECT 0 2 5 20 abcd0001 5 0 0 0 0
t2_same_cycle DISP 2 6 3 21 0 32 0 1 00 100
t2_same_cycle WB 32 0badf00d 0 0 0 0 0 0 0 0
t2_same_cycle IDLE 3 0 0 0 0 0 0 0 0 0
t2_same_cycle EXPECT 0 3 6 21 0badf00d 100 0 0 0 0
t3_round_robin DISP 0 1 4 04 0 40 0 1 00 4
t3_round_robin IDLE 1 0 0 0 0 0 0 0 0 0
t3_round_robin DISP 1 5 5 05 0 40 0 1 00 5
t3_round_robin IDLE 1 0 0 0 0 0 0 0 0 0
t3_round_robin DISP 2 6 6 06 0 40 0 1 00 6
t3_round_robin IDLE 1 0 0 0 0 0 0 0 0 0
t3_round_robin DISP 3 8 7 07 0 40 0 1 00 7
t3_round_robin IDLE 1 0 0 0 0 0 0 0 0 0
t3_round_robin WB 40 7 0 0 0 0 0 0 0 0
t3_round_robin IDLE 6 0 0 0 0 0 0 0 0 0
t3_round_robin EXPECT 0 7 8 07 7 7 0 0 0 0
t3_round_robin EXPECT 0 4 1 04 7 4 0 0 0 0
t3_round_robin EXPECT 0 5 5 05 7 5 0 0 0 0
t3_round_robin EXPECT 0 6 6 06 7 6 0 0 0 0
t4_full DISP 3 8 a 0a 0 50 0 1 00 a
t4_full IDLE 1 0 0 0 0 0 0 0 0 0
t4_full DISP 3 8 b 0b 0 50 0 1 00 b
t4_full IDLE 1 0 0 0 0 0 0 0 0 0
t4_full DISP 3 8 c 0c 0 50 0 1 00 c
t4_full IDLE 1 0 0 0 0 0 0 0 0 0
t4_full EXPECT 1 8 0 0 0 0 0 0 0 0
t4_full DISP 3 8 d 0d 0 50 0 1 00 d
t4_full IDLE 1 0 0 0 0 0 0 0 0 0
t4_full EXPECT 1 8 1 0 0 0 0 0 0 0
t4_full WB 50 55 0 0 0 0 0 0 0 0
t4_full IDLE 4 0 0 0 0 0 0 0 0 0
t4_full EXPECT 0 a 8 0a 55 a 0 0 0 0
t4_full EXPECT 0 b 8 0b 55 b 0 0 0 0
t4_full EXPECT 0 c 8 0c 55 c 0 0 0 0
t4_full IDLE 1 0 0 0 0 0 0 0 0 0
t4_full EXPECT 1 0 0 0 0 0 0 0 0 0
t5_stall STALL 1 0 0 0 0 0 0 0 0 0
t5_stall IDLE 1 0 0 0 0 0 0 0 0 0
t5_stall DISP 1 5 e 0e 1 01 e0 1 02 e1
t5_stall IDLE 1 0 0 0 0 0 0 0 0 0
t5_stall DISP 2 6 f 0f 1 01 f0 1 02 f1
t5_stall IDLE 6 0 0 0 0 0 0 0 0 0
t5_stall STALL 0 0 0 0 0 0 0 0 0 0
t5_stall IDLE 3 0 0 0 0 0 0 0 0 0
t5_stall EXPECT 0 e 5 0e e0 e1 0 0 0 0
t5_stall EXPECT 0 f 6 0f f0 f1 0 0 0 0
t6_stomp DISP 0 1 0 30 0 60 0 1 00 10
t6_stomp IDLE 1 0 0 0 0 0 0 0 0 0
t6_stomp DISP 1 5 1 31 0 60 0 1 00 11
t6_stomp IDLE 1 0 0 0 0 0 0 0 0 0
t6_stomp STOMP 0001 0 0 0 0 0 0 0 0 0
t6_stomp IDLE 1 0 0 0 0 0 0 0 0 0
t6_stomp DISP 2 6 2 32 1 01 20 1 02 21
t6_stomp STOMP 0004 0 0 0 0 0 0 0 0 0
t6_stomp IDLE 1 0 0 0 0 0 0 0 0 0
t6_stomp DISP 3 9 3 33 1 01 30 1 02 31
t6_stomp IDLE 1 0 0 0 0 0 0 0 0 0
t6_stomp WB 60 66 0 0 0 0 0 0 0 0
t6_stomp IDLE 4 0 0 0 0 0 0 0 0 0
t6_stomp EXPECT 0 3 9 33 30 31 0 0 0 0
t6_stomp EXPECT 0 1 5 31 66 11 0 0 0 0

/* tests/tb_clock.sv */
// ==========================================================================
// Free-running 4 ns clock for the testbench
// ==========================================================================
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #2 clk_o = ~clk_o;
	end

endmodule
